/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ahb_master_top
FILELIST = ahb_master_top.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* ahb_burst_engine.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ahb_master_settings.svh"

module ahb_burst_engine (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    ahb_req_if.responder            req,
    output ahb_master_pkg::addr_t   ahb_addr,
    output ahb_master_pkg::hburst_t ahb_burst,
    output ahb_master_pkg::hsize_t  ahb_size,
    output ahb_master_pkg::htrans_t ahb_trans,
    output logic                    ahb_write,
    output ahb_master_pkg::data_t   ahb_wdata,
    input  ahb_master_pkg::data_t   ahb_rdata,
    input  logic                    ahb_ready,
    input  logic                    ahb_resp
);

    localparam int WAIT_W = $clog2(`AHB_WAIT_TIMEOUT + 1);

    ahb_master_pkg::engine_state_t state;
    ahb_master_pkg::beat_cnt_t     beats_left;   // beats still to issue after the current one
    ahb_master_pkg::beat_cnt_t     first_beats;
    ahb_master_pkg::addr_t         size_bytes;
    ahb_master_pkg::addr_t         addr_inc;
    ahb_master_pkg::addr_t         wrap_mask;
    ahb_master_pkg::addr_t         next_addr;
    logic                          dp_pend;      // a data phase is in flight
    logic                          addr_done;
    logic                          resp_err;
    logic                          timeout;
    logic [WAIT_W-1:0]             wait_cnt;

    always_comb begin
        case (req.burst)
            ahb_master_pkg::HBURST_INCR4, ahb_master_pkg::HBURST_WRAP4: first_beats = 4'd3;
            ahb_master_pkg::HBURST_INCR8, ahb_master_pkg::HBURST_WRAP8: first_beats = 4'd7;
            default:                                                    first_beats = 4'd0;
        endcase
    end

    // wrap bursts keep the upper address bits and let only the low block bits roll over
    always_comb begin
        size_bytes = ahb_master_pkg::addr_t'(1) << ahb_size;
        addr_inc   = ahb_addr + size_bytes;
        case (ahb_burst)
            ahb_master_pkg::HBURST_WRAP4: wrap_mask = (size_bytes << 2) - 1'b1;
            ahb_master_pkg::HBURST_WRAP8: wrap_mask = (size_bytes << 3) - 1'b1;
            default:                      wrap_mask = '1;
        endcase
        next_addr = (ahb_addr & ~wrap_mask) | (addr_inc & wrap_mask);
    end

    assign resp_err  = dp_pend && ahb_resp;
    assign addr_done = (state == ahb_master_pkg::ENG_ADDR) && ahb_ready && !resp_err;
    assign timeout   = (state != ahb_master_pkg::ENG_IDLE) && !ahb_ready
                       && (wait_cnt == WAIT_W'(`AHB_WAIT_TIMEOUT - 1));

    assign req.ready      = (state == ahb_master_pkg::ENG_IDLE);
    assign req.wdata_take = addr_done && ahb_write;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            state           <= ahb_master_pkg::ENG_IDLE;
            ahb_trans       <= ahb_master_pkg::HTRANS_IDLE;
            ahb_addr        <= '0;
            ahb_burst       <= ahb_master_pkg::HBURST_SINGLE;
            ahb_size        <= '0;
            ahb_write       <= 1'b0;
            beats_left      <= '0;
            dp_pend         <= 1'b0;
            wait_cnt        <= '0;
            req.rdata_valid <= 1'b0;
            req.done        <= 1'b0;
            req.error       <= 1'b0;
        end else begin
            req.rdata_valid <= 1'b0;
            req.done        <= 1'b0;
            req.error       <= 1'b0;
            wait_cnt        <= ahb_ready ? '0 : wait_cnt + 1'b1;
            case (state)
                ahb_master_pkg::ENG_IDLE: begin
                    wait_cnt <= '0;
                    if (req.valid) begin
                        ahb_addr   <= req.addr;
                        ahb_burst  <= req.burst;
                        ahb_size   <= req.size;
                        ahb_write  <= req.write;
                        ahb_trans  <= ahb_master_pkg::HTRANS_NONSEQ;
                        beats_left <= first_beats;
                        state      <= ahb_master_pkg::ENG_ADDR;
                    end
                end
                ahb_master_pkg::ENG_ADDR, ahb_master_pkg::ENG_LAST: begin
                    if (resp_err) begin  // cancel the rest of the burst
                        ahb_trans <= ahb_master_pkg::HTRANS_IDLE;
                        dp_pend   <= 1'b0;
                        state     <= ahb_master_pkg::ENG_ERROR;
                    end else if (ahb_ready) begin
                        req.rdata_valid <= dp_pend && !ahb_write;
                        if (state == ahb_master_pkg::ENG_LAST) begin
                            dp_pend  <= 1'b0;
                            req.done <= 1'b1;
                            state    <= ahb_master_pkg::ENG_IDLE;
                        end else if (beats_left != '0) begin
                            dp_pend    <= 1'b1;
                            ahb_addr   <= next_addr;
                            ahb_trans  <= ahb_master_pkg::HTRANS_SEQ;
                            beats_left <= beats_left - 1'b1;
                        end else begin
                            dp_pend   <= 1'b1;
                            ahb_trans <= ahb_master_pkg::HTRANS_IDLE;
                            state     <= ahb_master_pkg::ENG_LAST;
                        end
                    end
                end
                ahb_master_pkg::ENG_ERROR: begin
                    if (ahb_ready) begin
                        req.done  <= 1'b1;
                        req.error <= 1'b1;
                        state     <= ahb_master_pkg::ENG_IDLE;
                    end
                end
                default: state <= ahb_master_pkg::ENG_IDLE;
            endcase
            if (timeout) begin  // slave stalled too long, give up on the request
                ahb_trans <= ahb_master_pkg::HTRANS_IDLE;
                dp_pend   <= 1'b0;
                wait_cnt  <= '0;
                req.done  <= 1'b1;
                req.error <= 1'b1;
                state     <= ahb_master_pkg::ENG_IDLE;
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (req.wdata_take) begin
            ahb_wdata <= req.wdata;  // held through the following data phase
        end
        if (dp_pend && ahb_ready) begin
            req.rdata <= ahb_rdata;
        end
    end

endmodule

`default_nettype wire

/* ahb_master_pkg.sv */
`default_nettype none

package ahb_master_pkg;

`include "ahb_master_settings.svh"

    typedef logic [`AHB_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AHB_DATA_WIDTH-1:0] data_t;
    typedef logic [2:0] hsize_t;  // bytes per beat is 2**hsize
    typedef logic [2:0] hburst_t;
    typedef logic [1:0] htrans_t;
    typedef logic [3:0] beat_cnt_t;

    localparam hburst_t HBURST_SINGLE = 3'd0;
    localparam hburst_t HBURST_INCR   = 3'd1;  // undefined length, rejected by the channels
    localparam hburst_t HBURST_WRAP4  = 3'd2;
    localparam hburst_t HBURST_INCR4  = 3'd3;
    localparam hburst_t HBURST_WRAP8  = 3'd4;
    localparam hburst_t HBURST_INCR8  = 3'd5;

    localparam htrans_t HTRANS_IDLE   = 2'd0;
    localparam htrans_t HTRANS_NONSEQ = 2'd2;
    localparam htrans_t HTRANS_SEQ    = 2'd3;

    typedef enum logic [1:0] {
        ENG_IDLE,   // waiting for a request
        ENG_ADDR,   // an address phase is on the bus
        ENG_LAST,   // only the final data phase is left
        ENG_ERROR   // second cycle of an ERROR response
    } engine_state_t;

endpackage

`default_nettype wire

/* ahb_master_settings.svh */
`ifndef AHB_MASTER_SETTINGS_SVH
`define AHB_MASTER_SETTINGS_SVH

`define AHB_ADDR_WIDTH 32

`define AHB_DATA_WIDTH 32

// consecutive cycles with ready low before a request is abandoned
`define AHB_WAIT_TIMEOUT 6

// a burst must stay inside one 2**AHB_BOUNDARY_BITS byte block
`define AHB_BOUNDARY_BITS 10

`endif

/* ahb_master_top.f */
+incdir+.
ahb_master_pkg.sv
ahb_req_if.sv
ahb_request_channel.sv
ahb_request_arbiter.sv
ahb_burst_engine.sv
ahb_master_top.sv
ahb_master_top_checker.sv
tb_ahb_master_top.sv

/* ahb_master_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ahb_master_top (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,

    input  logic                    c0_req_valid,
    output logic                    c0_req_ready,
    input  logic                    c0_write,
    input  ahb_master_pkg::addr_t   c0_addr,
    input  ahb_master_pkg::hburst_t c0_burst,
    input  ahb_master_pkg::hsize_t  c0_size,
    input  ahb_master_pkg::data_t   c0_wdata,
    output logic                    c0_wdata_take,
    output ahb_master_pkg::data_t   c0_rdata,
    output logic                    c0_rdata_valid,
    output logic                    c0_done,
    output logic                    c0_error,

    input  logic                    c1_req_valid,
    output logic                    c1_req_ready,
    input  logic                    c1_write,
    input  ahb_master_pkg::addr_t   c1_addr,
    input  ahb_master_pkg::hburst_t c1_burst,
    input  ahb_master_pkg::hsize_t  c1_size,
    input  ahb_master_pkg::data_t   c1_wdata,
    output logic                    c1_wdata_take,
    output ahb_master_pkg::data_t   c1_rdata,
    output logic                    c1_rdata_valid,
    output logic                    c1_done,
    output logic                    c1_error,

    output ahb_master_pkg::addr_t   ahb_addr,
    output ahb_master_pkg::hburst_t ahb_burst,
    output ahb_master_pkg::hsize_t  ahb_size,
    output ahb_master_pkg::htrans_t ahb_trans,
    output logic                    ahb_write,
    output ahb_master_pkg::data_t   ahb_wdata,
    input  ahb_master_pkg::data_t   ahb_rdata,
    input  logic                    ahb_ready,
    input  logic                    ahb_resp
);

    ahb_req_if ch0_if ();
    ahb_req_if ch1_if ();
    ahb_req_if eng_if ();

    ahb_request_channel u_channel0 (
        .ahb_clk_in  (ahb_clk_in),     .ahb_rstn_in (ahb_rstn_in),
        .req_valid   (c0_req_valid),   .req_ready   (c0_req_ready),
        .write       (c0_write),       .addr        (c0_addr),
        .burst       (c0_burst),       .size        (c0_size),
        .wdata       (c0_wdata),       .wdata_take  (c0_wdata_take),
        .rdata       (c0_rdata),       .rdata_valid (c0_rdata_valid),
        .done        (c0_done),        .error       (c0_error),
        .bus         (ch0_if)
    );

    ahb_request_channel u_channel1 (
        .ahb_clk_in  (ahb_clk_in),     .ahb_rstn_in (ahb_rstn_in),
        .req_valid   (c1_req_valid),   .req_ready   (c1_req_ready),
        .write       (c1_write),       .addr        (c1_addr),
        .burst       (c1_burst),       .size        (c1_size),
        .wdata       (c1_wdata),       .wdata_take  (c1_wdata_take),
        .rdata       (c1_rdata),       .rdata_valid (c1_rdata_valid),
        .done        (c1_done),        .error       (c1_error),
        .bus         (ch1_if)
    );

    ahb_request_arbiter u_arbiter (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .ch0         (ch0_if),
        .ch1         (ch1_if),
        .eng         (eng_if)
    );

    ahb_burst_engine u_engine (
        .ahb_clk_in  (ahb_clk_in),     .ahb_rstn_in (ahb_rstn_in),
        .req         (eng_if),
        .ahb_addr    (ahb_addr),       .ahb_burst   (ahb_burst),
        .ahb_size    (ahb_size),       .ahb_trans   (ahb_trans),
        .ahb_write   (ahb_write),      .ahb_wdata   (ahb_wdata),
        .ahb_rdata   (ahb_rdata),      .ahb_ready   (ahb_ready),
        .ahb_resp    (ahb_resp)
    );

endmodule

`default_nettype wire

/* ahb_master_top_checker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ahb_master_settings.svh"

module ahb_master_top_checker (
    input logic                    ahb_clk_in,
    input logic                    ahb_rstn_in,
    input ahb_master_pkg::htrans_t ahb_trans,
    input ahb_master_pkg::addr_t   ahb_addr,
    input ahb_master_pkg::hburst_t ahb_burst,
    input ahb_master_pkg::hsize_t  ahb_size,
    input logic                    ahb_write,
    input logic                    ahb_ready,
    input logic                    c0_done,
    input logic                    c0_error,
    input logic                    c1_done,
    input logic                    c1_error
);

    seq_after_idle: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        ahb_trans == ahb_master_pkg::HTRANS_IDLE |=> ahb_trans != ahb_master_pkg::HTRANS_SEQ)
        else $error("SEQ transfer directly after IDLE");

    // an ERROR response or a timeout may drop the transfer to IDLE while stalled
    hold_when_stalled: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        (ahb_trans != ahb_master_pkg::HTRANS_IDLE && !ahb_ready) |=>
        (ahb_trans == ahb_master_pkg::HTRANS_IDLE) ||
        ($stable(ahb_addr) && $stable(ahb_trans) && $stable(ahb_burst)
         && $stable(ahb_size) && $stable(ahb_write)))
        else $error("address or control changed while ready was low");

    same_block: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        ahb_trans == ahb_master_pkg::HTRANS_SEQ |->
        ahb_addr[`AHB_ADDR_WIDTH-1:`AHB_BOUNDARY_BITS]
        == $past(ahb_addr[`AHB_ADDR_WIDTH-1:`AHB_BOUNDARY_BITS]))
        else $error("burst crossed the address boundary");

    quiet_in_reset: assert property (@(posedge ahb_clk_in)
        !ahb_rstn_in |-> !(c0_done || c0_error || c1_done || c1_error))
        else $error("done or error raised during reset");

endmodule

bind ahb_master_top ahb_master_top_checker checker_inst (
    .ahb_clk_in (ahb_clk_in),  .ahb_rstn_in (ahb_rstn_in),
    .ahb_trans  (ahb_trans),   .ahb_addr    (ahb_addr),
    .ahb_burst  (ahb_burst),   .ahb_size    (ahb_size),
    .ahb_write  (ahb_write),   .ahb_ready   (ahb_ready),
    .c0_done    (c0_done),     .c0_error    (c0_error),
    .c1_done    (c1_done),     .c1_error    (c1_error)
);

`default_nettype wire

/* ahb_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface ahb_req_if;

    logic                    valid;
    logic                    write;
    ahb_master_pkg::addr_t   addr;
    ahb_master_pkg::hburst_t burst;
    ahb_master_pkg::hsize_t  size;
    ahb_master_pkg::data_t   wdata;        // sampled in the wdata_take cycle

    logic                    ready;
    logic                    wdata_take;
    ahb_master_pkg::data_t   rdata;
    logic                    rdata_valid;
    logic                    done;
    logic                    error;        // only meaningful together with done

    modport requester (
        output valid, write, addr, burst, size, wdata,
        input  ready, wdata_take, rdata, rdata_valid, done, error
    );

    modport responder (
        input  valid, write, addr, burst, size, wdata,
        output ready, wdata_take, rdata, rdata_valid, done, error
    );

endinterface

`default_nettype wire

/* ahb_request_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module ahb_request_arbiter (
    input  logic          ahb_clk_in,
    input  logic          ahb_rstn_in,
    ahb_req_if.responder  ch0,
    ahb_req_if.responder  ch1,
    ahb_req_if.requester  eng
);

    logic granted;
    logic last_sel;  // channel served last, also the current owner while granted
    logic pick;
    logic route0;
    logic route1;

    // with both pending the channel not served last goes first
    assign pick = (ch0.valid && ch1.valid) ? !last_sel : ch1.valid;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            granted  <= 1'b0;
            last_sel <= 1'b1;
        end else if (!granted) begin
            if (ch0.valid || ch1.valid) begin
                granted  <= 1'b1;
                last_sel <= pick;
            end
        end else if (eng.done) begin
            granted <= 1'b0;
        end
    end

    assign route0 = granted && !last_sel;
    assign route1 = granted && last_sel;

    assign eng.valid = granted && (last_sel ? ch1.valid : ch0.valid);
    assign eng.write = last_sel ? ch1.write : ch0.write;
    assign eng.addr  = last_sel ? ch1.addr : ch0.addr;
    assign eng.burst = last_sel ? ch1.burst : ch0.burst;
    assign eng.size  = last_sel ? ch1.size : ch0.size;
    assign eng.wdata = last_sel ? ch1.wdata : ch0.wdata;

    assign ch0.ready       = route0 && eng.ready;
    assign ch0.wdata_take  = route0 && eng.wdata_take;
    assign ch0.rdata       = route0 ? eng.rdata : '0;
    assign ch0.rdata_valid = route0 && eng.rdata_valid;
    assign ch0.done        = route0 && eng.done;
    assign ch0.error       = route0 && eng.error;

    assign ch1.ready       = route1 && eng.ready;
    assign ch1.wdata_take  = route1 && eng.wdata_take;
    assign ch1.rdata       = route1 ? eng.rdata : '0;
    assign ch1.rdata_valid = route1 && eng.rdata_valid;
    assign ch1.done        = route1 && eng.done;
    assign ch1.error       = route1 && eng.error;

endmodule

`default_nettype wire

/* ahb_request_channel.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ahb_master_settings.svh"

module ahb_request_channel (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    write,
    input  ahb_master_pkg::addr_t   addr,
    input  ahb_master_pkg::hburst_t burst,
    input  ahb_master_pkg::hsize_t  size,
    input  ahb_master_pkg::data_t   wdata,
    output logic                    wdata_take,
    output ahb_master_pkg::data_t   rdata,
    output logic                    rdata_valid,
    output logic                    done,
    output logic                    error,
    ahb_req_if.requester            bus
);

    logic                      accept;
    logic                      busy;
    logic                      err_stage;
    logic                      local_done;
    logic                      aligned;
    logic                      size_ok;
    logic                      burst_ok;
    logic                      crosses;
    logic                      req_ok;
    ahb_master_pkg::beat_cnt_t span_beats;
    ahb_master_pkg::addr_t     size_bytes;
    ahb_master_pkg::addr_t     last_addr;

    always_comb begin
        burst_ok   = 1'b1;
        span_beats = '0;  // wrap blocks are aligned and far smaller than the boundary block
        case (burst)
            ahb_master_pkg::HBURST_SINGLE: span_beats = 4'd0;
            ahb_master_pkg::HBURST_INCR4:  span_beats = 4'd3;
            ahb_master_pkg::HBURST_INCR8:  span_beats = 4'd7;
            ahb_master_pkg::HBURST_WRAP4,
            ahb_master_pkg::HBURST_WRAP8:  span_beats = 4'd0;
            ahb_master_pkg::HBURST_INCR:   burst_ok = 1'b0;
            default:                       burst_ok = 1'b0;
        endcase
    end

    assign size_bytes = ahb_master_pkg::addr_t'(1) << size;
    assign last_addr  = addr + (ahb_master_pkg::addr_t'(span_beats) << size);
    assign aligned    = (addr & (size_bytes - 1'b1)) == '0;
    assign size_ok    = (32'd8 << size) <= `AHB_DATA_WIDTH;
    assign crosses    = last_addr[`AHB_ADDR_WIDTH-1:`AHB_BOUNDARY_BITS]
                        != addr[`AHB_ADDR_WIDTH-1:`AHB_BOUNDARY_BITS];
    assign req_ok     = aligned && size_ok && burst_ok && !crosses;
    assign accept     = req_valid && req_ready;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            req_ready  <= 1'b0;
            busy       <= 1'b0;
            bus.valid  <= 1'b0;
            err_stage  <= 1'b0;
            local_done <= 1'b0;
        end else begin
            req_ready  <= req_valid && !busy && !req_ready;  // one-cycle pulse while empty
            err_stage  <= accept && !req_ok;
            local_done <= err_stage;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (accept && req_ok) begin
                bus.valid <= 1'b1;
            end else if (bus.ready) begin
                bus.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (accept) begin
            bus.write <= write;
            bus.addr  <= addr;
            bus.burst <= burst;
            bus.size  <= size;
        end
    end

    assign bus.wdata   = wdata;  // per-beat data comes straight from the client
    assign wdata_take  = bus.wdata_take;
    assign rdata       = bus.rdata;
    assign rdata_valid = bus.rdata_valid;
    assign done        = bus.done || local_done;
    assign error       = bus.error || local_done;

endmodule

`default_nettype wire

/* tb_ahb_master_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_master_top;

    localparam int NUM_ROWS = 21;
    localparam int LIMIT    = 200;

    // the err column is 0 when a request completes, 1 when the channel rejects it
    // and 2 when the slave ends it
    typedef struct {
        int                      client;
        logic                    write;
        ahb_master_pkg::addr_t   addr;
        ahb_master_pkg::hburst_t burst;
        ahb_master_pkg::hsize_t  size;
        int                      err;
        int                      src;
    } row_t;

    logic ahb_clk_in;
    logic ahb_rstn_in;
    logic c0_req_valid, c0_req_ready, c0_write, c0_wdata_take, c0_rdata_valid;
    logic c0_done, c0_error;
    logic c1_req_valid, c1_req_ready, c1_write, c1_wdata_take, c1_rdata_valid;
    logic c1_done, c1_error;
    ahb_master_pkg::addr_t   c0_addr, c1_addr, ahb_addr;
    ahb_master_pkg::hburst_t c0_burst, c1_burst, ahb_burst;
    ahb_master_pkg::hsize_t  c0_size, c1_size, ahb_size;
    ahb_master_pkg::data_t   c0_wdata, c1_wdata, c0_rdata, c1_rdata;
    ahb_master_pkg::data_t   ahb_wdata, ahb_rdata;
    ahb_master_pkg::htrans_t ahb_trans;
    logic ahb_write, ahb_ready, ahb_resp;

    row_t                    rows [NUM_ROWS];
    ahb_master_pkg::data_t   mem [4096];  // one bus word per byte address
    ahb_master_pkg::addr_t   addr_log [$];
    ahb_master_pkg::hburst_t burst_log [$];
    ahb_master_pkg::hsize_t  size_log [$];
    int                      trans_cycles;

    ahb_master_top ahb_master_top_inst (.*);

    initial begin
        ahb_clk_in = 1'b0;
        forever #5 ahb_clk_in = ~ahb_clk_in;
    end

    // AHB slave with random wait states, an ERROR region and a stall region
    initial begin
        logic                  dp_active;
        logic                  dp_write;
        ahb_master_pkg::addr_t dp_addr;
        int                    waits;
        int                    phase;
        void'($urandom(41041));
        for (int i = 0; i < 4096; i++) mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0101);
        ahb_ready = 1'b1;
        ahb_resp  = 1'b0;
        ahb_rdata = '0;
        dp_active = 1'b0;
        forever begin
            @(posedge ahb_clk_in);
            if (ahb_trans != ahb_master_pkg::HTRANS_IDLE) trans_cycles++;
            if (dp_active && ahb_ready) begin
                if (dp_write && dp_addr[11:8] < 4'h8) mem[dp_addr[11:0]] = ahb_wdata;
                dp_active = 1'b0;
            end
            if (ahb_ready && ahb_trans[1]) begin
                dp_active = 1'b1;
                dp_addr   = ahb_addr;
                dp_write  = ahb_write;
                waits     = $urandom % 3;
                phase     = 0;
                addr_log.push_back(ahb_addr);
                burst_log.push_back(ahb_burst);
                size_log.push_back(ahb_size);
            end
            #1;
            ahb_resp = 1'b0;
            if (!dp_active) begin
                ahb_ready = 1'b1;
            end else if (dp_addr[11:8] == 4'h8) begin  // two-cycle ERROR response
                ahb_resp  = 1'b1;
                ahb_ready = (phase == 1);
                phase++;
            end else if (dp_addr[11:8] == 4'h9) begin
                ahb_ready = (phase >= 9);
                phase++;
            end else if (waits != 0) begin
                ahb_ready = 1'b0;
                waits--;
            end else begin
                ahb_ready = 1'b1;
                ahb_rdata = mem[dp_addr[11:0]];
            end
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input ahb_master_pkg::data_t got,
                              input ahb_master_pkg::data_t exp);
        if (got !== exp) stop_run($sformatf("** Error at %0t: %s expected %h got %h",
                                            $time, name, exp, got));
    endtask

    task automatic check_addr(input string name, input ahb_master_pkg::addr_t got,
                              input ahb_master_pkg::addr_t exp);
        if (got !== exp) stop_run($sformatf("** Error at %0t: %s expected %h got %h",
                                            $time, name, exp, got));
    endtask

    task automatic check_burst(input string name, input ahb_master_pkg::hburst_t got,
                               input ahb_master_pkg::hburst_t exp);
        if (got !== exp) stop_run($sformatf("** Error at %0t: %s expected %h got %h",
                                            $time, name, exp, got));
    endtask

    task automatic check_size(input string name, input ahb_master_pkg::hsize_t got,
                              input ahb_master_pkg::hsize_t exp);
        if (got !== exp) stop_run($sformatf("** Error at %0t: %s expected %h got %h",
                                            $time, name, exp, got));
    endtask

    task automatic check_error(input string name, input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("** Error at %0t: %s expected %b got %b",
                                            $time, name, exp, got));
    endtask

    function automatic int beats_of(input ahb_master_pkg::hburst_t burst);
        if (burst == ahb_master_pkg::HBURST_INCR4 || burst == ahb_master_pkg::HBURST_WRAP4)
            return 4;
        if (burst == ahb_master_pkg::HBURST_INCR8 || burst == ahb_master_pkg::HBURST_WRAP8)
            return 8;
        return 1;
    endfunction

    // a wrap burst stays inside the aligned block of beats times bytes that holds its start
    function automatic ahb_master_pkg::addr_t beat_addr(input row_t row, input int k);
        ahb_master_pkg::addr_t bytes;
        ahb_master_pkg::addr_t block;
        ahb_master_pkg::addr_t base;
        bytes = 32'd1 << row.size;
        block = bytes * beats_of(row.burst);
        if (row.burst == ahb_master_pkg::HBURST_WRAP4
            || row.burst == ahb_master_pkg::HBURST_WRAP8) begin
            base = row.addr - (row.addr % block);
            return base + ((row.addr - base + k * bytes) % block);
        end
        return row.addr + k * bytes;
    endfunction

    // compare the logged address phases of one row, starting at log entry first
    task automatic check_bus_log(input int r, input int first);
        for (int k = 0; k < beats_of(rows[r].burst); k++) begin
            check_addr("ahb_addr", addr_log[first + k], beat_addr(rows[r], k));
            check_burst("ahb_burst", burst_log[first + k], rows[r].burst);
            check_size("ahb_size", size_log[first + k], rows[r].size);
        end
    endtask

    task automatic drive_client(input int c, input logic valid, input row_t row,
                                input ahb_master_pkg::data_t wdata);
        if (c == 0) begin
            c0_req_valid = valid;
            c0_write     = row.write;
            c0_addr      = row.addr;
            c0_burst     = row.burst;
            c0_size      = row.size;
            c0_wdata     = wdata;
        end else begin
            c1_req_valid = valid;
            c1_write     = row.write;
            c1_addr      = row.addr;
            c1_burst     = row.burst;
            c1_size      = row.size;
            c1_wdata     = wdata;
        end
    endtask

    task automatic run_request(input int r);
        row_t row;
        int   c;
        int   cycles;
        int   k_w;
        int   k_r;
        logic rdy, take, rv, dn, er;
        ahb_master_pkg::data_t rd;
        row    = rows[r];
        c      = row.client;
        k_w    = 0;
        k_r    = 0;
        cycles = 0;
        drive_client(c, 1'b1, row, r * 256);
        do begin
            @(posedge ahb_clk_in);
            rdy = (c == 0) ? c0_req_ready : c1_req_ready;
            cycles++;
            if (cycles > LIMIT) stop_run($sformatf("row %0d was never accepted", r));
        end while (!rdy);
        #1;
        drive_client(c, 1'b0, row, r * 256);
        cycles = 0;
        do begin
            @(posedge ahb_clk_in);
            take = (c == 0) ? c0_wdata_take : c1_wdata_take;
            rv   = (c == 0) ? c0_rdata_valid : c1_rdata_valid;
            rd   = (c == 0) ? c0_rdata : c1_rdata;
            dn   = (c == 0) ? c0_done : c1_done;
            er   = (c == 0) ? c0_error : c1_error;
            if (rv) begin
                check_data($sformatf("c%0d_rdata", c), rd, row.src * 256 + k_r);
                k_r++;
            end
            cycles++;
            if (cycles > LIMIT) stop_run($sformatf("row %0d never signalled done", r));
            #1;
            if (take) begin
                k_w++;
                drive_client(c, 1'b0, row, r * 256 + k_w);
            end
        end while (!dn);
        check_error($sformatf("c%0d_error", c), er, row.err != 0);
        if (row.err == 0 && (row.write ? k_w : k_r) != beats_of(row.burst))
            stop_run($sformatf("row %0d moved the wrong number of beats", r));
    endtask

    initial begin
        trans_cycles = 0;
        // client, write, address, burst, size, err, source row of the read data
        rows[0]  = '{0, 1, 32'h200, ahb_master_pkg::HBURST_INCR4, 3'd2, 0, 0};
        rows[1]  = '{1, 1, 32'h300, ahb_master_pkg::HBURST_INCR4, 3'd2, 0, 0};
        rows[2]  = '{0, 0, 32'h200, ahb_master_pkg::HBURST_INCR4, 3'd2, 0, 0};
        rows[3]  = '{1, 0, 32'h300, ahb_master_pkg::HBURST_INCR4, 3'd2, 0, 1};
        rows[4]  = '{0, 1, 32'h010, ahb_master_pkg::HBURST_SINGLE, 3'd2, 0, 0};
        rows[5]  = '{1, 0, 32'h010, ahb_master_pkg::HBURST_SINGLE, 3'd2, 0, 4};
        rows[6]  = '{1, 1, 32'h020, ahb_master_pkg::HBURST_SINGLE, 3'd2, 0, 0};
        rows[7]  = '{0, 0, 32'h020, ahb_master_pkg::HBURST_SINGLE, 3'd2, 0, 6};
        rows[8]  = '{0, 1, 32'h400, ahb_master_pkg::HBURST_INCR8, 3'd1, 0, 0};
        rows[9]  = '{1, 0, 32'h400, ahb_master_pkg::HBURST_INCR8, 3'd1, 0, 8};
        rows[10] = '{1, 1, 32'h518, ahb_master_pkg::HBURST_WRAP4, 3'd2, 0, 0};
        rows[11] = '{0, 0, 32'h518, ahb_master_pkg::HBURST_WRAP4, 3'd2, 0, 10};
        rows[12] = '{0, 1, 32'h634, ahb_master_pkg::HBURST_WRAP8, 3'd2, 0, 0};
        rows[13] = '{1, 0, 32'h634, ahb_master_pkg::HBURST_WRAP8, 3'd2, 0, 12};
        rows[14] = '{0, 0, 32'h102, ahb_master_pkg::HBURST_SINGLE, 3'd2, 1, 0};
        rows[15] = '{1, 1, 32'h3F8, ahb_master_pkg::HBURST_INCR4, 3'd2, 1, 0};
        rows[16] = '{0, 0, 32'h100, ahb_master_pkg::HBURST_SINGLE, 3'd3, 1, 0};
        rows[17] = '{1, 0, 32'h100, ahb_master_pkg::HBURST_INCR, 3'd2, 1, 0};
        rows[18] = '{0, 0, 32'h800, ahb_master_pkg::HBURST_SINGLE, 3'd2, 2, 0};
        rows[19] = '{1, 1, 32'h900, ahb_master_pkg::HBURST_SINGLE, 3'd2, 2, 0};
        rows[20] = '{1, 0, 32'h010, ahb_master_pkg::HBURST_SINGLE, 3'd2, 0, 4};
        drive_client(0, 1'b0, rows[0], '0);
        drive_client(1, 1'b0, rows[1], '0);
        ahb_rstn_in = 1'b0;
        repeat (8) @(posedge ahb_clk_in);
        #1;
        ahb_rstn_in = 1'b1;
        fork  // both clients request in the same cycle and c0 has to own the bus first
            run_request(0);
            run_request(1);
        join
        if (addr_log.size() != 8) stop_run("the two first bursts did not give eight beats");
        check_bus_log(0, 0);
        check_bus_log(1, 4);
        for (int r = 2; r < NUM_ROWS; r++) begin
            addr_log.delete();
            burst_log.delete();
            size_log.delete();
            trans_cycles = 0;
            run_request(r);
            if (rows[r].err == 1 && trans_cycles != 0)
                stop_run($sformatf("rejected row %0d reached the bus", r));
            if (rows[r].err == 0) begin
                if (addr_log.size() != beats_of(rows[r].burst))
                    stop_run($sformatf("row %0d issued the wrong number of beats", r));
                check_bus_log(r, 0);
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
